// File: hdl/csr_rs_pkg.sv
package csr_rs_pkg;

  // ##################################################
  // station sizes
  // ##################################################

  localparam int RS_DEPTH   = 8;
  localparam int SLOT_W     = 3;
  localparam int SEQ_W      = 4;  // one extra bit tells full from empty
  localparam int TAG_W      = 8;
  localparam int XLEN       = 32;
  localparam int CSR_ADDR_W = 12;
  localparam int NUM_WB     = 3;
  localparam int ZIMM_W     = 5;  // rs1 field used as an immediate

  // occupancy count that marks the station as full
  localparam logic [SEQ_W-1:0] RS_FULL_CNT = SEQ_W'(RS_DEPTH);

  // ##################################################
  // opcodes
  // ##################################################

  localparam int CSR_OP_W = 2;

  localparam logic [CSR_OP_W-1:0] CSR_OP_RW = 2'd1;  // write source
  localparam logic [CSR_OP_W-1:0] CSR_OP_RS = 2'd2;  // set bits
  localparam logic [CSR_OP_W-1:0] CSR_OP_RC = 2'd3;  // clear bits

  // ##################################################
  // implemented machine mode CSRs
  // ##################################################

  localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC    = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC     = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE   = 12'h342;

  // ##################################################
  // issue FSM encoding
  // ##################################################

  localparam int ST_W = 1;

  localparam logic [ST_W-1:0] ST_IDLE = 1'b0;
  localparam logic [ST_W-1:0] ST_BUSY = 1'b1;  // one access in flight

endpackage

// File: hdl/csr_rs_slots.sv
`timescale 1ns/1ns

module csr_rs_slots (
  input  logic                                                 clk,
  input  logic                                                 arst_n,
  input  logic                                                 flush,
  input  logic                                                 disp_valid,
  input  logic [csr_rs_pkg::CSR_OP_W-1:0]                      disp_op,
  input  logic [csr_rs_pkg::CSR_ADDR_W-1:0]                    disp_csr_addr,
  input  logic                                                 disp_src_imm,
  input  logic [csr_rs_pkg::ZIMM_W-1:0]                        disp_zimm,
  input  logic                                                 disp_src_ready,
  input  logic [csr_rs_pkg::TAG_W-1:0]                         disp_src_tag,
  input  logic [csr_rs_pkg::XLEN-1:0]                          disp_src_value,
  input  logic [csr_rs_pkg::TAG_W-1:0]                         disp_rd_tag,
  input  logic [csr_rs_pkg::NUM_WB-1:0]                        wb_valid,
  input  logic [csr_rs_pkg::NUM_WB-1:0][csr_rs_pkg::TAG_W-1:0] wb_tag,
  input  logic [csr_rs_pkg::NUM_WB-1:0][csr_rs_pkg::XLEN-1:0]  wb_data,
  input  logic                                                 csr_done,
  input  logic [csr_rs_pkg::TAG_W-1:0]                         csr_done_tag,
  input  logic [csr_rs_pkg::XLEN-1:0]                          csr_done_value,
  input  logic [csr_rs_pkg::SEQ_W-1:0]                         alloc_seq,
  input  logic [csr_rs_pkg::SEQ_W-1:0]                         issue_seq,
  input  logic                                                 issue,
  output logic                                                 head_ready,
  output logic [csr_rs_pkg::CSR_OP_W-1:0]                      head_op,
  output logic [csr_rs_pkg::CSR_ADDR_W-1:0]                    head_csr_addr,
  output logic [csr_rs_pkg::XLEN-1:0]                          head_src_value,
  output logic [csr_rs_pkg::TAG_W-1:0]                         head_rd_tag
);

  logic [csr_rs_pkg::RS_DEPTH-1:0]   slot_valid;
  logic [csr_rs_pkg::RS_DEPTH-1:0]   slot_rdy;
  logic [csr_rs_pkg::SEQ_W-1:0]      slot_seq     [csr_rs_pkg::RS_DEPTH];
  logic [csr_rs_pkg::CSR_OP_W-1:0]   slot_op      [csr_rs_pkg::RS_DEPTH];
  logic [csr_rs_pkg::CSR_ADDR_W-1:0] slot_addr    [csr_rs_pkg::RS_DEPTH];
  logic [csr_rs_pkg::TAG_W-1:0]      slot_rd_tag  [csr_rs_pkg::RS_DEPTH];
  logic [csr_rs_pkg::TAG_W-1:0]      slot_src_tag [csr_rs_pkg::RS_DEPTH];
  logic [csr_rs_pkg::XLEN-1:0]       slot_val     [csr_rs_pkg::RS_DEPTH];

  logic [csr_rs_pkg::XLEN:0]         slot_wake    [csr_rs_pkg::RS_DEPTH];  // {hit, data}
  logic [csr_rs_pkg::XLEN:0]         disp_wake;
  logic                              disp_ready;
  logic [csr_rs_pkg::XLEN-1:0]       disp_value;
  logic [csr_rs_pkg::SLOT_W-1:0]     free_idx;
  logic                              free_found;
  logic [csr_rs_pkg::SLOT_W-1:0]     head_idx;
  logic                              head_hit;
  logic                              alloc;

  // checks one tag against every result bus and the station's own CSR result
  function automatic logic [csr_rs_pkg::XLEN:0] wake_lookup(
    input logic [csr_rs_pkg::TAG_W-1:0] tag
  );
    logic [csr_rs_pkg::XLEN:0] hit;
    hit = '0;
    for (int b = 0; b < csr_rs_pkg::NUM_WB; b++) begin
      if (wb_valid[b] && wb_tag[b] == tag) begin
        hit = {1'b1, wb_data[b]};
      end
    end
    if (csr_done && csr_done_tag == tag) begin
      hit = {1'b1, csr_done_value};
    end
    return hit;
  endfunction

  always_comb begin
    disp_wake = wake_lookup(disp_src_tag);
    for (int i = 0; i < csr_rs_pkg::RS_DEPTH; i++) begin
      slot_wake[i] = wake_lookup(slot_src_tag[i]);
    end
  end

  assign disp_ready = disp_src_imm || disp_src_ready || disp_wake[csr_rs_pkg::XLEN];

  always_comb begin
    if (disp_src_imm) begin
      disp_value = {{(csr_rs_pkg::XLEN - csr_rs_pkg::ZIMM_W){1'b0}}, disp_zimm};
    end else if (disp_src_ready) begin
      disp_value = disp_src_value;
    end else begin
      disp_value = disp_wake[csr_rs_pkg::XLEN-1:0];  // bus value or don't care until wakeup
    end
  end

  // ##################################################
  // free slot and head selection
  // ##################################################

  always_comb begin
    free_idx   = '0;
    free_found = 1'b0;
    head_idx   = '0;
    head_hit   = 1'b0;
    for (int i = csr_rs_pkg::RS_DEPTH - 1; i >= 0; i--) begin
      if (!slot_valid[i]) begin
        free_idx   = i[csr_rs_pkg::SLOT_W-1:0];  // lowest free slot wins
        free_found = 1'b1;
      end
      if (slot_valid[i] && slot_seq[i] == issue_seq) begin
        head_idx = i[csr_rs_pkg::SLOT_W-1:0];
        head_hit = 1'b1;
      end
    end
  end

  assign alloc          = disp_valid && free_found;
  assign head_ready     = head_hit && slot_rdy[head_idx];
  assign head_op        = slot_op[head_idx];
  assign head_csr_addr  = slot_addr[head_idx];
  assign head_src_value = slot_val[head_idx];
  assign head_rd_tag    = slot_rd_tag[head_idx];

  // ##################################################
  // slot state
  // ##################################################

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slot_valid <= '0;
      slot_rdy   <= '0;
    end else if (flush) begin
      slot_valid <= '0;
      slot_rdy   <= '0;
    end else begin
      for (int i = 0; i < csr_rs_pkg::RS_DEPTH; i++) begin
        if (slot_valid[i] && !slot_rdy[i] && slot_wake[i][csr_rs_pkg::XLEN]) begin
          slot_rdy[i] <= 1'b1;
        end
      end
      if (issue) begin
        slot_valid[head_idx] <= 1'b0;
      end
      if (alloc) begin
        slot_valid[free_idx] <= 1'b1;
        slot_rdy[free_idx]   <= disp_ready;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < csr_rs_pkg::RS_DEPTH; i++) begin
      if (slot_valid[i] && !slot_rdy[i] && slot_wake[i][csr_rs_pkg::XLEN]) begin
        slot_val[i] <= slot_wake[i][csr_rs_pkg::XLEN-1:0];
      end
    end
    if (alloc) begin
      slot_seq[free_idx]     <= alloc_seq;  // age stamp for in-order issue
      slot_op[free_idx]      <= disp_op;
      slot_addr[free_idx]    <= disp_csr_addr;
      slot_rd_tag[free_idx]  <= disp_rd_tag;
      slot_src_tag[free_idx] <= disp_src_tag;
      slot_val[free_idx]     <= disp_value;
    end
  end

endmodule

// File: hdl/csr_seq_tracker.sv
`timescale 1ns/1ns

module csr_seq_tracker (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         flush,
  input  logic                         disp_valid,
  input  logic                         issue,
  output logic [csr_rs_pkg::SEQ_W-1:0] alloc_seq,
  output logic [csr_rs_pkg::SEQ_W-1:0] issue_seq,
  output logic                         rs_full
);

  logic [csr_rs_pkg::SEQ_W-1:0] occupancy;
  logic                         accept;

  // the extra counter bit keeps eight entries apart from none
  assign occupancy = alloc_seq - issue_seq;
  assign rs_full   = (occupancy == csr_rs_pkg::RS_FULL_CNT);
  assign accept    = disp_valid && !rs_full;  // a dispatch while full is dropped

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      alloc_seq <= '0;
      issue_seq <= '0;
    end else if (flush) begin
      alloc_seq <= '0;
      issue_seq <= '0;
    end else begin
      if (accept) begin
        alloc_seq <= alloc_seq + 1'b1;
      end
      if (issue) begin
        issue_seq <= issue_seq + 1'b1;  // counters wrap together
      end
    end
  end

endmodule

// File: hdl/csr_issue_fsm.sv
`timescale 1ns/1ns

module csr_issue_fsm (
  input  logic clk,
  input  logic arst_n,
  input  logic flush,
  input  logic head_ready,
  input  logic exec_done,
  output logic issue
);

  logic [csr_rs_pkg::ST_W-1:0] state;

  // ##################################################
  // one access at a time keeps CSR side effects in order
  // ##################################################

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= csr_rs_pkg::ST_IDLE;
      issue <= 1'b0;
    end else if (flush) begin
      state <= csr_rs_pkg::ST_IDLE;
      issue <= 1'b0;
    end else begin
      issue <= 1'b0;
      case (state)
        csr_rs_pkg::ST_IDLE: begin
          if (head_ready) begin
            state <= csr_rs_pkg::ST_BUSY;
            issue <= 1'b1;
          end
        end
        csr_rs_pkg::ST_BUSY: begin
          // the done cycle acts as idle so ready entries follow without a gap
          if (exec_done) begin
            if (head_ready) begin
              issue <= 1'b1;
            end else begin
              state <= csr_rs_pkg::ST_IDLE;
            end
          end
        end
        default: state <= csr_rs_pkg::ST_IDLE;
      endcase
    end
  end

endmodule

// File: hdl/csr_file_unit.sv
`timescale 1ns/1ns

module csr_file_unit (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              flush,
  input  logic                              issue,
  input  logic [csr_rs_pkg::CSR_OP_W-1:0]   op,
  input  logic [csr_rs_pkg::CSR_ADDR_W-1:0] csr_addr,
  input  logic [csr_rs_pkg::XLEN-1:0]       src_value,
  input  logic [csr_rs_pkg::TAG_W-1:0]      rd_tag,
  output logic                              csr_done,
  output logic                              csr_illegal,
  output logic [csr_rs_pkg::TAG_W-1:0]      csr_done_tag,
  output logic [csr_rs_pkg::XLEN-1:0]       csr_done_value,
  output logic                              exec_done
);

  logic [csr_rs_pkg::XLEN-1:0]       mtvec;
  logic [csr_rs_pkg::XLEN-1:0]       mscratch;
  logic [csr_rs_pkg::XLEN-1:0]       mepc;
  logic [csr_rs_pkg::XLEN-1:0]       mcause;

  logic                              rd_valid;  // read cycle
  logic                              wr_valid;  // write cycle
  logic [csr_rs_pkg::CSR_OP_W-1:0]   op_q;
  logic [csr_rs_pkg::CSR_ADDR_W-1:0] addr_q;
  logic [csr_rs_pkg::XLEN-1:0]       src_q;
  logic [csr_rs_pkg::TAG_W-1:0]      tag_q;
  logic [csr_rs_pkg::XLEN-1:0]       old_q;
  logic                              illegal_q;

  logic [csr_rs_pkg::XLEN-1:0]       rd_data;
  logic                              rd_illegal;
  logic [csr_rs_pkg::XLEN-1:0]       new_value;

  always_comb begin
    rd_illegal = 1'b0;
    case (addr_q)
      csr_rs_pkg::ADDR_MTVEC:    rd_data = mtvec;
      csr_rs_pkg::ADDR_MSCRATCH: rd_data = mscratch;
      csr_rs_pkg::ADDR_MEPC:     rd_data = mepc;
      csr_rs_pkg::ADDR_MCAUSE:   rd_data = mcause;
      default: begin
        rd_data    = '0;
        rd_illegal = 1'b1;
      end
    endcase
  end

  always_comb begin
    case (op_q)
      csr_rs_pkg::CSR_OP_RW: new_value = src_q;
      csr_rs_pkg::CSR_OP_RS: new_value = old_q | src_q;
      csr_rs_pkg::CSR_OP_RC: new_value = old_q & ~src_q;
      default:               new_value = old_q;
    endcase
  end

  // ##################################################
  // pipeline control and CSR storage
  // ##################################################

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid <= 1'b0;
      wr_valid <= 1'b0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
    end else begin
      rd_valid <= issue && !flush;
      wr_valid <= rd_valid && !flush;  // flush drops the access before its write
      if (wr_valid && !illegal_q) begin
        case (addr_q)
          csr_rs_pkg::ADDR_MTVEC:    mtvec    <= new_value;
          csr_rs_pkg::ADDR_MSCRATCH: mscratch <= new_value;
          csr_rs_pkg::ADDR_MEPC:     mepc     <= new_value;
          csr_rs_pkg::ADDR_MCAUSE:   mcause   <= new_value;
          default:                   mcause   <= mcause;
        endcase
      end
    end
  end

  // operands stay put until the next issue, which comes after the write cycle
  always_ff @(posedge clk) begin
    if (issue) begin
      op_q   <= op;
      addr_q <= csr_addr;
      src_q  <= src_value;
      tag_q  <= rd_tag;
    end
    if (rd_valid) begin
      old_q     <= rd_data;
      illegal_q <= rd_illegal;
    end
  end

  assign csr_done       = wr_valid;
  assign exec_done      = wr_valid;
  assign csr_illegal    = wr_valid && illegal_q;
  assign csr_done_tag   = tag_q;
  assign csr_done_value = old_q;

endmodule

// File: hdl/csr_rs_top.sv
`timescale 1ns/1ns

module csr_rs_top (
  input  logic                                                 clk,
  input  logic                                                 arst_n,
  input  logic                                                 disp_valid,
  input  logic [csr_rs_pkg::CSR_OP_W-1:0]                      disp_op,
  input  logic [csr_rs_pkg::CSR_ADDR_W-1:0]                    disp_csr_addr,
  input  logic                                                 disp_src_imm,
  input  logic [csr_rs_pkg::ZIMM_W-1:0]                        disp_zimm,
  input  logic                                                 disp_src_ready,
  input  logic [csr_rs_pkg::TAG_W-1:0]                         disp_src_tag,
  input  logic [csr_rs_pkg::XLEN-1:0]                          disp_src_value,
  input  logic [csr_rs_pkg::TAG_W-1:0]                         disp_rd_tag,
  input  logic [csr_rs_pkg::NUM_WB-1:0]                        wb_valid,
  input  logic [csr_rs_pkg::NUM_WB-1:0][csr_rs_pkg::TAG_W-1:0] wb_tag,
  input  logic [csr_rs_pkg::NUM_WB-1:0][csr_rs_pkg::XLEN-1:0]  wb_data,
  input  logic                                                 exception_sig,
  input  logic                                                 mret_sig,
  output logic                                                 rs_full,
  output logic                                                 csr_done,
  output logic                                                 csr_illegal,
  output logic [csr_rs_pkg::TAG_W-1:0]                         csr_done_tag,
  output logic [csr_rs_pkg::XLEN-1:0]                          csr_done_value
);

  logic                              flush;
  logic [csr_rs_pkg::SEQ_W-1:0]      alloc_seq;
  logic [csr_rs_pkg::SEQ_W-1:0]      issue_seq;
  logic                              issue;
  logic                              exec_done;
  logic                              head_ready;
  logic [csr_rs_pkg::CSR_OP_W-1:0]   head_op;
  logic [csr_rs_pkg::CSR_ADDR_W-1:0] head_csr_addr;
  logic [csr_rs_pkg::XLEN-1:0]       head_src_value;
  logic [csr_rs_pkg::TAG_W-1:0]      head_rd_tag;

  assign flush = exception_sig || mret_sig;  // either trap event empties the station

  csr_rs_slots i_slots (
    .clk            (clk),
    .arst_n         (arst_n),
    .flush          (flush),
    .disp_valid     (disp_valid),
    .disp_op        (disp_op),
    .disp_csr_addr  (disp_csr_addr),
    .disp_src_imm   (disp_src_imm),
    .disp_zimm      (disp_zimm),
    .disp_src_ready (disp_src_ready),
    .disp_src_tag   (disp_src_tag),
    .disp_src_value (disp_src_value),
    .disp_rd_tag    (disp_rd_tag),
    .wb_valid       (wb_valid),
    .wb_tag         (wb_tag),
    .wb_data        (wb_data),
    .csr_done       (csr_done),
    .csr_done_tag   (csr_done_tag),
    .csr_done_value (csr_done_value),
    .alloc_seq      (alloc_seq),
    .issue_seq      (issue_seq),
    .issue          (issue),
    .head_ready     (head_ready),
    .head_op        (head_op),
    .head_csr_addr  (head_csr_addr),
    .head_src_value (head_src_value),
    .head_rd_tag    (head_rd_tag)
  );

  csr_seq_tracker i_seq (
    .clk        (clk),
    .arst_n     (arst_n),
    .flush      (flush),
    .disp_valid (disp_valid),
    .issue      (issue),
    .alloc_seq  (alloc_seq),
    .issue_seq  (issue_seq),
    .rs_full    (rs_full)
  );

  csr_issue_fsm i_fsm (
    .clk        (clk),
    .arst_n     (arst_n),
    .flush      (flush),
    .head_ready (head_ready),
    .exec_done  (exec_done),
    .issue      (issue)
  );

  csr_file_unit i_csr (
    .clk            (clk),
    .arst_n         (arst_n),
    .flush          (flush),
    .issue          (issue),
    .op             (head_op),
    .csr_addr       (head_csr_addr),
    .src_value      (head_src_value),
    .rd_tag         (head_rd_tag),
    .csr_done       (csr_done),
    .csr_illegal    (csr_illegal),
    .csr_done_tag   (csr_done_tag),
    .csr_done_value (csr_done_value),
    .exec_done      (exec_done)
  );

endmodule

// File: sim/tb_csr_rs.sv
`timescale 1ns/1ns

module tb_csr_rs;

  localparam int K_DISP  = 0;
  localparam int K_WAKE  = 1;
  localparam int K_FLUSH = 2;
  localparam int K_IDLE  = 3;
  localparam int K_CHECK = 4;  // aux 0 checks rs_full, aux 1 checks csr_done
  localparam int K_DRAIN = 5;  // aux holds the test number

  typedef struct {
    int                                kind;
    logic [csr_rs_pkg::CSR_OP_W-1:0]   op;
    logic [csr_rs_pkg::CSR_ADDR_W-1:0] addr;
    logic                              imm;
    logic [csr_rs_pkg::ZIMM_W-1:0]     zimm;
    logic                              src_rdy;
    logic [csr_rs_pkg::TAG_W-1:0]      src_tag;
    logic [csr_rs_pkg::XLEN-1:0]       src_val;
    logic [csr_rs_pkg::TAG_W-1:0]      rd_tag;
    int                                aux;
    logic                              flag;
  } step_t;

  typedef struct {
    logic [csr_rs_pkg::CSR_OP_W-1:0]   op;
    logic [csr_rs_pkg::CSR_ADDR_W-1:0] addr;
    logic                              resolved;
    logic [csr_rs_pkg::TAG_W-1:0]      src_tag;
    logic [csr_rs_pkg::XLEN-1:0]       src;
    logic [csr_rs_pkg::TAG_W-1:0]      rd_tag;
  } entry_t;

  typedef struct {
    logic [csr_rs_pkg::XLEN-1:0]  value;
    logic [csr_rs_pkg::TAG_W-1:0] tag;
    logic                         illegal;
  } result_t;

  logic                                                 clk;
  logic                                                 arst_n;
  logic                                                 disp_valid;
  logic [csr_rs_pkg::CSR_OP_W-1:0]                      disp_op;
  logic [csr_rs_pkg::CSR_ADDR_W-1:0]                    disp_csr_addr;
  logic                                                 disp_src_imm;
  logic [csr_rs_pkg::ZIMM_W-1:0]                        disp_zimm;
  logic                                                 disp_src_ready;
  logic [csr_rs_pkg::TAG_W-1:0]                         disp_src_tag;
  logic [csr_rs_pkg::XLEN-1:0]                          disp_src_value;
  logic [csr_rs_pkg::TAG_W-1:0]                         disp_rd_tag;
  logic [csr_rs_pkg::NUM_WB-1:0]                        wb_valid;
  logic [csr_rs_pkg::NUM_WB-1:0][csr_rs_pkg::TAG_W-1:0] wb_tag;
  logic [csr_rs_pkg::NUM_WB-1:0][csr_rs_pkg::XLEN-1:0]  wb_data;
  logic                                                 exception_sig;
  logic                                                 mret_sig;
  logic                                                 rs_full;
  logic                                                 csr_done;
  logic                                                 csr_illegal;
  logic [csr_rs_pkg::TAG_W-1:0]                         csr_done_tag;
  logic [csr_rs_pkg::XLEN-1:0]                          csr_done_value;

  step_t                       steps[$];
  entry_t                      pend_q[$];  // dispatched entries not yet modeled
  result_t                     exp_q[$];   // expected completions in dispatch order
  result_t                     seen;
  logic [csr_rs_pkg::XLEN-1:0] ref_csr[4];
  logic [csr_rs_pkg::XLEN-1:0] result_by_tag[2**csr_rs_pkg::TAG_W];  // modeled old values
  logic                        result_known[2**csr_rs_pkg::TAG_W];
  string                       test_name[6];
  int                          checks;
  int                          errors;
  int                          test_errors;
  int                          cycle_cnt;
  int                          timeout_limit;

  csr_rs_top i_dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .disp_valid     (disp_valid),
    .disp_op        (disp_op),
    .disp_csr_addr  (disp_csr_addr),
    .disp_src_imm   (disp_src_imm),
    .disp_zimm      (disp_zimm),
    .disp_src_ready (disp_src_ready),
    .disp_src_tag   (disp_src_tag),
    .disp_src_value (disp_src_value),
    .disp_rd_tag    (disp_rd_tag),
    .wb_valid       (wb_valid),
    .wb_tag         (wb_tag),
    .wb_data        (wb_data),
    .exception_sig  (exception_sig),
    .mret_sig       (mret_sig),
    .rs_full        (rs_full),
    .csr_done       (csr_done),
    .csr_illegal    (csr_illegal),
    .csr_done_tag   (csr_done_tag),
    .csr_done_value (csr_done_value)
  );

  always #4 clk = ~clk;

  // ##################################################
  // compare tasks
  // ##################################################

  task automatic check_data(input string name, input logic [csr_rs_pkg::XLEN-1:0] got,
                            input logic [csr_rs_pkg::XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_tag(input string name, input logic [csr_rs_pkg::TAG_W-1:0] got,
                           input logic [csr_rs_pkg::TAG_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  // ##################################################
  // reference CSR model
  // ##################################################

  function automatic int csr_index(input logic [csr_rs_pkg::CSR_ADDR_W-1:0] addr);
    case (addr)
      12'h305: return 0;
      12'h340: return 1;
      12'h341: return 2;
      12'h342: return 3;
      default: return -1;
    endcase
  endfunction

  // retires modeled entries in order while the oldest one has its operand
  task automatic retire_ready_entries();
    entry_t                      ent;
    result_t                     res;
    int                          idx;
    logic [csr_rs_pkg::XLEN-1:0] old_val;
    while (pend_q.size() > 0 && pend_q[0].resolved) begin
      ent     = pend_q.pop_front();
      idx     = csr_index(ent.addr);
      old_val = (idx < 0) ? '0 : ref_csr[idx];
      if (idx >= 0) begin
        case (ent.op)
          2'd1:    ref_csr[idx] = ent.src;
          2'd2:    ref_csr[idx] = old_val | ent.src;
          2'd3:    ref_csr[idx] = old_val & ~ent.src;
          default: ref_csr[idx] = old_val;
        endcase
      end
      res.value   = old_val;
      res.tag     = ent.rd_tag;
      res.illegal = (idx < 0);
      exp_q.push_back(res);
      result_by_tag[ent.rd_tag] = old_val;
      result_known[ent.rd_tag]  = 1'b1;
      foreach (pend_q[j]) begin
        if (!pend_q[j].resolved && pend_q[j].src_tag == ent.rd_tag) begin
          pend_q[j].resolved = 1'b1;  // woken by the CSR result itself
          pend_q[j].src      = old_val;
        end
      end
    end
  endtask

  task automatic resolve_wake(input logic [csr_rs_pkg::TAG_W-1:0] tag,
                              input logic [csr_rs_pkg::XLEN-1:0] data);
    foreach (pend_q[j]) begin
      if (!pend_q[j].resolved && pend_q[j].src_tag == tag) begin
        pend_q[j].resolved = 1'b1;
        pend_q[j].src      = data;
      end
    end
    retire_ready_entries();
  endtask

  // ##################################################
  // stimulus table
  // ##################################################

  task automatic add_disp(input logic [1:0] op, input logic [11:0] addr, input logic imm,
                          input logic [4:0] zimm, input logic rdy, input logic [7:0] stag,
                          input logic [31:0] sval, input logic [7:0] rd);
    step_t s;
    s = '{K_DISP, op, addr, imm, zimm, rdy, stag, sval, rd, 0, 1'b0};
    steps.push_back(s);
  endtask

  task automatic add_ctrl(input int kind, input logic [7:0] tag, input int aux, input logic flag);
    step_t s;
    s = '{kind, 2'd0, 12'h0, 1'b0, 5'd0, 1'b0, tag, 32'h0, 8'h0, aux, flag};
    steps.push_back(s);
  endtask

  task automatic read_all_csrs(input logic [7:0] rd_base);
    add_disp(2'd2, 12'h305, 1'b1, 5'd0, 1'b0, 8'h0, 32'h0, rd_base);
    add_disp(2'd2, 12'h340, 1'b1, 5'd0, 1'b0, 8'h0, 32'h0, rd_base + 8'd1);
    add_disp(2'd2, 12'h341, 1'b1, 5'd0, 1'b0, 8'h0, 32'h0, rd_base + 8'd2);
    add_disp(2'd2, 12'h342, 1'b1, 5'd0, 1'b0, 8'h0, 32'h0, rd_base + 8'd3);
  endtask

  task automatic build_table();
    add_ctrl(K_CHECK, 8'h0, 0, 1'b0);  // reset values
    add_ctrl(K_CHECK, 8'h0, 1, 1'b0);
    read_all_csrs(8'h10);
    add_ctrl(K_DRAIN, 8'h0, 0, 1'b0);
    add_disp(2'd1, 12'h305, 1'b0, 5'd0, 1'b1, 8'h0, 32'h8000_0100, 8'h20);
    add_disp(2'd2, 12'h340, 1'b1, 5'h1f, 1'b0, 8'h0, 32'h0, 8'h21);
    add_disp(2'd1, 12'h341, 1'b0, 5'd0, 1'b1, 8'h0, 32'hdead_beef, 8'h22);
    add_disp(2'd3, 12'h341, 1'b1, 5'h0f, 1'b0, 8'h0, 32'h0, 8'h23);
    add_disp(2'd2, 12'h342, 1'b0, 5'd0, 1'b1, 8'h0, 32'h8000_000b, 8'h24);
    add_disp(2'd3, 12'h342, 1'b0, 5'd0, 1'b1, 8'h0, 32'h8000_0000, 8'h25);
    add_disp(2'd1, 12'h340, 1'b1, 5'h0a, 1'b0, 8'h0, 32'h0, 8'h26);
    read_all_csrs(8'h27);
    add_ctrl(K_DRAIN, 8'h0, 1, 1'b0);
    add_disp(2'd1, 12'h340, 1'b0, 5'd0, 1'b0, 8'h81, 32'h0, 8'h30);  // waits on bus
    add_disp(2'd2, 12'h305, 1'b0, 5'd0, 1'b1, 8'h0, 32'h3, 8'h31);
    add_ctrl(K_IDLE, 8'h0, 0, 1'b0);
    add_ctrl(K_WAKE, 8'h81, 1, 1'b0);
    read_all_csrs(8'h32);
    add_ctrl(K_DRAIN, 8'h0, 2, 1'b0);
    add_disp(2'd1, 12'h341, 1'b0, 5'd0, 1'b1, 8'h0, 32'h0000_1234, 8'h40);
    add_disp(2'd1, 12'h342, 1'b0, 5'd0, 1'b0, 8'h40, 32'h0, 8'h41);  // waits on csr_done
    add_disp(2'd2, 12'h305, 1'b0, 5'd0, 1'b0, 8'h41, 32'h0, 8'h42);
    read_all_csrs(8'h43);
    add_ctrl(K_DRAIN, 8'h0, 3, 1'b0);
    add_disp(2'd1, 12'h7c0, 1'b0, 5'd0, 1'b1, 8'h0, 32'hffff_ffff, 8'h50);
    add_disp(2'd2, 12'h300, 1'b1, 5'd3, 1'b0, 8'h0, 32'h0, 8'h51);
    read_all_csrs(8'h52);
    add_ctrl(K_DRAIN, 8'h0, 4, 1'b0);
    for (int i = 0; i < 8; i++) begin
      add_disp(2'(i % 3 + 1), 12'h340, 1'b0, 5'd0, 1'b0, 8'(8'h90 + i), 32'h0, 8'(8'h60 + i));
    end
    add_ctrl(K_CHECK, 8'h0, 0, 1'b1);
    add_ctrl(K_FLUSH, 8'h0, 0, 1'b0);  // exception
    add_ctrl(K_CHECK, 8'h0, 0, 1'b0);
    add_ctrl(K_WAKE, 8'h90, 0, 1'b0);  // nothing left to wake
    add_disp(2'd1, 12'h305, 1'b0, 5'd0, 1'b0, 8'h98, 32'h0, 8'h68);
    add_ctrl(K_FLUSH, 8'h0, 0, 1'b1);  // mret
    add_ctrl(K_IDLE, 8'h0, 0, 1'b0);
    add_ctrl(K_CHECK, 8'h0, 1, 1'b0);
    read_all_csrs(8'h70);
    add_ctrl(K_DRAIN, 8'h0, 5, 1'b0);
  endtask

  // ##################################################
  // driving
  // ##################################################

  task automatic clear_pulses();
    disp_valid    <= 1'b0;
    wb_valid      <= '0;
    exception_sig <= 1'b0;
    mret_sig      <= 1'b0;
  endtask

  task automatic apply_step(input step_t s);
    entry_t                      ent;
    logic [csr_rs_pkg::XLEN-1:0] data;
    int                          gap;
    @(posedge clk);
    clear_pulses();
    case (s.kind)
      K_DISP: begin
        disp_valid     <= 1'b1;
        disp_op        <= s.op;
        disp_csr_addr  <= s.addr;
        disp_src_imm   <= s.imm;
        disp_zimm      <= s.zimm;
        disp_src_ready <= s.src_rdy;
        disp_src_tag   <= s.src_tag;
        disp_src_value <= s.src_val;
        disp_rd_tag    <= s.rd_tag;
        ent.op         = s.op;
        ent.addr       = s.addr;
        ent.resolved   = s.imm || s.src_rdy;
        ent.src_tag    = s.src_tag;
        ent.src        = s.imm ? {27'd0, s.zimm} : s.src_val;  // zimm is zero-extended
        ent.rd_tag     = s.rd_tag;
        if (!ent.resolved && result_known[s.src_tag]) begin
          ent.resolved = 1'b1;  // the producer's csr_done is still ahead of this entry
          ent.src      = result_by_tag[s.src_tag];
        end
        pend_q.push_back(ent);
        retire_ready_entries();
      end
      K_WAKE: begin
        data                = $urandom;
        wb_valid[s.aux]     <= 1'b1;
        wb_tag[s.aux]       <= s.src_tag;
        wb_data[s.aux]      <= data;
        resolve_wake(s.src_tag, data);
      end
      K_FLUSH: begin
        if (s.flag) begin
          mret_sig <= 1'b1;
        end else begin
          exception_sig <= 1'b1;
        end
        pend_q.delete();  // flushed entries never complete
      end
      K_IDLE: begin
        gap = 1 + int'($urandom % 3);
        repeat (gap) @(posedge clk);
      end
      K_CHECK: begin
        @(negedge clk);
        if (s.aux == 0) begin
          check_bit("rs_full", rs_full, s.flag);
        end else begin
          check_bit("csr_done", csr_done, s.flag);
        end
      end
      K_DRAIN: begin
        while (pend_q.size() > 0 || exp_q.size() > 0) @(posedge clk);
        repeat (3) @(posedge clk);
        if (test_errors == 0) begin
          $display("test %0d %s: ok", s.aux + 1, test_name[s.aux]);
        end else begin
          $display("test %0d %s: failed with %0d errors", s.aux + 1, test_name[s.aux],
                   test_errors);
        end
        test_errors = 0;
      end
      default: ;
    endcase
  endtask

  // results are sampled away from the driving edge
  always @(negedge clk) begin
    if (arst_n && csr_done) begin
      if (exp_q.size() == 0) begin
        errors++;
        test_errors++;
        $display("csr_done arrived with tag %h while no completion was expected", csr_done_tag);
      end else begin
        seen = exp_q.pop_front();
        check_data("csr_done_value", csr_done_value, seen.value);
        check_tag("csr_done_tag", csr_done_tag, seen.tag);
        check_bit("csr_illegal", csr_illegal, seen.illegal);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
      $display("timeout: run did not finish within %0d cycles", timeout_limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    clk            = 1'b0;
    arst_n         = 1'b0;
    disp_valid     = 1'b0;
    disp_op        = '0;
    disp_csr_addr  = '0;
    disp_src_imm   = 1'b0;
    disp_zimm      = '0;
    disp_src_ready = 1'b0;
    disp_src_tag   = '0;
    disp_src_value = '0;
    disp_rd_tag    = '0;
    wb_valid       = '0;
    wb_tag         = '0;
    wb_data        = '0;
    exception_sig  = 1'b0;
    mret_sig       = 1'b0;
    checks         = 0;
    errors         = 0;
    test_errors    = 0;
    cycle_cnt      = 0;
    timeout_limit  = 0;
    ref_csr        = '{default: '0};
    result_known   = '{default: 1'b0};
    test_name      = '{"reset state", "read modify write", "bus wakeup order",
                       "csr result wakeup", "illegal address", "full and flush"};
    void'($urandom(88));
    build_table();
    timeout_limit  = 20 * steps.size() + 100;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    foreach (steps[i]) begin
      apply_step(steps[i]);
    end
    @(posedge clk);
    clear_pulses();
    repeat (4) @(posedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: csr_rs.f
hdl/csr_rs_pkg.sv
hdl/csr_rs_slots.sv
hdl/csr_seq_tracker.sv
hdl/csr_issue_fsm.sv
hdl/csr_file_unit.sv
hdl/csr_rs_top.sv
sim/tb_csr_rs.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_csr_rs
RTL_TOP   ?= csr_rs_top
FILELIST  ?= csr_rs.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
